// ==== common/eth_ip_pkg.sv ====
package eth_ip_pkg;

    // Frame format constants
    localparam logic [15:0] ETH_TYPE_IPV4 = 16'h0800;
    localparam logic [7:0]  IP_VER_IHL    = 8'h45;   // IPv4, 20 byte header
    localparam logic [7:0]  REPLY_TTL     = 8'd64;
    localparam int          HDR_BYTES     = 34;      // 14 Ethernet + 20 IPv4

    // Addresses after reset
    localparam logic [47:0] DEFAULT_MAC = 48'h02_00_00_00_00_01;
    localparam logic [31:0] DEFAULT_IP  = 32'hC0_A8_01_64;  // 192.168.1.100
    localparam logic [47:0] BCAST_MAC   = 48'hFF_FF_FF_FF_FF_FF;

    // Register map
    localparam logic [1:0] CFG_ADDR_IP     = 2'd0;
    localparam logic [1:0] CFG_ADDR_MAC_LO = 2'd1;  // MAC bits 31:0
    localparam logic [1:0] CFG_ADDR_MAC_HI = 2'd2;  // MAC bits 47:32

    localparam int PAYLOAD_FIFO_DEPTH = 16;
    localparam int HDR_FIFO_DEPTH     = 2;

    typedef struct packed {
        logic [47:0] mac;
        logic [31:0] ip;
    } local_addr_t;

    // Fields of an accepted frame needed for the reply
    typedef struct packed {
        logic [47:0] peer_mac;
        logic [31:0] peer_ip;
        logic [15:0] total_len;
        logic [7:0]  protocol;
    } rx_hdr_t;

    typedef struct packed {
        logic [7:0] data;
        logic       last;
    } byte_beat_t;

endpackage

// ==== source/ip_echo_regs.sv ====
`timescale 1ns/10ps

module ip_echo_regs
    import eth_ip_pkg::*;
(
    input  logic        i_clk,
    input  logic        i_rst_n,
    input  logic        i_cfg_wr,
    input  logic [1:0]  i_cfg_addr,
    input  logic [31:0] i_cfg_wdata,
    input  logic        i_drop,
    output local_addr_t o_local,
    output logic [15:0] o_drop_count
);

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_local.mac <= DEFAULT_MAC;
            o_local.ip  <= DEFAULT_IP;
        end else if (i_cfg_wr) begin
            case (i_cfg_addr)
                CFG_ADDR_IP:     o_local.ip         <= i_cfg_wdata;
                CFG_ADDR_MAC_LO: o_local.mac[31:0]  <= i_cfg_wdata;
                CFG_ADDR_MAC_HI: o_local.mac[47:32] <= i_cfg_wdata[15:0];
                default: ;                          // Unmapped address
            endcase
        end
    end

    // Saturating drop counter
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_drop_count <= '0;
        end else if (i_drop && (o_drop_count != 16'hFFFF)) begin
            o_drop_count <= o_drop_count + 16'd1;
        end
    end

endmodule

// ==== ip_rx/ip_rx_parser.sv ====
`timescale 1ns/10ps

module ip_rx_parser
    import eth_ip_pkg::*;
(
    input  logic        i_clk,
    input  logic        i_rst_n,
    input  local_addr_t i_local,
    input  logic [7:0]  i_rx_data,
    input  logic        i_rx_valid,
    input  logic        i_rx_last,
    output logic        o_rx_ready,
    output rx_hdr_t     o_hdr,
    output logic        o_hdr_push,
    input  logic        i_hdr_full,
    output byte_beat_t  o_beat,
    output logic        o_beat_push,
    input  logic        i_beat_full,
    output logic        o_drop
);

    typedef enum logic [1:0] {ST_HDR, ST_PAYLOAD, ST_DISCARD} state_t;

    state_t      state;
    logic [5:0]  byte_cnt;
    logic [47:0] dst_mac;
    logic [47:0] src_mac;
    logic [15:0] eth_type;
    logic [7:0]  ver_ihl;
    logic [15:0] total_len;
    logic [7:0]  protocol;
    logic [31:0] src_ip;
    logic [23:0] dst_ip_hi;   // First three bytes of the destination IP
    logic [7:0]  csum_hi;
    logic [15:0] csum;
    logic [16:0] word_sum;
    logic [15:0] csum_next;
    logic        accept;
    logic        hdr_end;
    logic        mac_ok;
    logic        frame_ok;

    assign accept  = i_rx_valid && o_rx_ready;
    assign hdr_end = (state == ST_HDR) && (byte_cnt == 6'(HDR_BYTES - 1));

    // Ones-complement add of the current word with end-around carry
    assign word_sum  = {1'b0, csum} + {1'b0, csum_hi, i_rx_data};
    assign csum_next = word_sum[15:0] + {15'd0, word_sum[16]};

    assign mac_ok   = (dst_mac == i_local.mac) || (dst_mac == BCAST_MAC);
    assign frame_ok = (eth_type == ETH_TYPE_IPV4) &&
                      (ver_ihl == IP_VER_IHL) &&
                      (csum_next == 16'hFFFF) &&
                      ({dst_ip_hi, i_rx_data} == i_local.ip) &&
                      mac_ok;

    always_comb begin
        case (state)
            ST_HDR:     o_rx_ready = !(hdr_end && i_hdr_full);  // Wait for a header slot
            ST_PAYLOAD: o_rx_ready = !i_beat_full;
            default:    o_rx_ready = 1'b1;                      // Discard runs free
        endcase
    end

    assign o_hdr.peer_mac  = src_mac;
    assign o_hdr.peer_ip   = src_ip;
    assign o_hdr.total_len = total_len;
    assign o_hdr.protocol  = protocol;
    assign o_hdr_push      = accept && hdr_end && frame_ok && !i_rx_last;

    assign o_beat.data = i_rx_data;
    assign o_beat.last = i_rx_last;
    assign o_beat_push = accept && (state == ST_PAYLOAD);

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            state    <= ST_HDR;
            byte_cnt <= '0;
            csum     <= '0;
            o_drop   <= 1'b0;
        end else begin
            o_drop <= 1'b0;
            if (accept) begin
                case (state)
                    ST_HDR: begin
                        if (i_rx_last) begin
                            // Runt frame, or a header with no payload to echo
                            byte_cnt <= '0;
                            csum     <= '0;
                            o_drop   <= 1'b1;
                        end else if (hdr_end) begin
                            byte_cnt <= '0;
                            csum     <= '0;
                            if (frame_ok) begin
                                state <= ST_PAYLOAD;
                            end else begin
                                state  <= ST_DISCARD;
                                o_drop <= 1'b1;
                            end
                        end else begin
                            byte_cnt <= byte_cnt + 6'd1;
                            if ((byte_cnt >= 6'd15) && byte_cnt[0]) begin
                                csum <= csum_next;   // Low byte of an IPv4 word
                            end
                        end
                    end
                    default: begin
                        if (i_rx_last) begin
                            state <= ST_HDR;
                        end
                    end
                endcase
            end
        end
    end

    // Header field capture by byte position
    always_ff @(posedge i_clk) begin
        if (accept && (state == ST_HDR)) begin
            if (!byte_cnt[0]) begin
                csum_hi <= i_rx_data;
            end
            if (byte_cnt < 6'd6) begin
                dst_mac <= {dst_mac[39:0], i_rx_data};
            end else if (byte_cnt < 6'd12) begin
                src_mac <= {src_mac[39:0], i_rx_data};
            end else if (byte_cnt < 6'd14) begin
                eth_type <= {eth_type[7:0], i_rx_data};
            end else if (byte_cnt == 6'd14) begin
                ver_ihl <= i_rx_data;
            end else if ((byte_cnt == 6'd16) || (byte_cnt == 6'd17)) begin
                total_len <= {total_len[7:0], i_rx_data};
            end else if (byte_cnt == 6'd23) begin
                protocol <= i_rx_data;
            end else if ((byte_cnt >= 6'd26) && (byte_cnt < 6'd30)) begin
                src_ip <= {src_ip[23:0], i_rx_data};
            end else if (byte_cnt >= 6'd30) begin
                dst_ip_hi <= {dst_ip_hi[15:0], i_rx_data};
            end
        end
    end

    // A stalled byte must stay put until the parser takes it
    a_rx_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_rx_valid && !o_rx_ready) |=>
            (i_rx_valid && $stable(i_rx_data) && $stable(i_rx_last)));

endmodule

// ==== source/sync_fifo.sv ====
`timescale 1ns/10ps

module sync_fifo #(
    parameter type T     = logic [7:0],
    parameter int  DEPTH = 4
) (
    input  logic i_clk,
    input  logic i_rst_n,
    input  logic i_push,
    input  T     i_data,
    output logic o_full,
    input  logic i_pop,
    output T     o_data,
    output logic o_empty
);

    T                         mem [DEPTH];
    logic [$clog2(DEPTH)-1:0] wr_ptr;
    logic [$clog2(DEPTH)-1:0] rd_ptr;
    logic [$clog2(DEPTH):0]   count;
    logic                     push_en;
    logic                     pop_en;

    assign o_full  = (int'(count) == DEPTH);
    assign o_empty = (count == '0);
    assign o_data  = mem[rd_ptr];          // First word falls through

    assign push_en = i_push && !o_full;
    assign pop_en  = i_pop && !o_empty;

    always_ff @(posedge i_clk) begin
        if (push_en) begin
            mem[wr_ptr] <= i_data;
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_en) begin
                wr_ptr <= (int'(wr_ptr) == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
            end
            if (pop_en) begin
                rd_ptr <= (int'(rd_ptr) == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
            end
            case ({push_en, pop_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
        end
    end

    a_no_overflow: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_push |-> !o_full);
    a_no_underflow: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_pop |-> !o_empty);

endmodule

// ==== ip_tx/ip_tx_builder.sv ====
`timescale 1ns/10ps

module ip_tx_builder
    import eth_ip_pkg::*;
(
    input  logic        i_clk,
    input  logic        i_rst_n,
    input  local_addr_t i_local,
    input  rx_hdr_t     i_hdr,
    input  logic        i_hdr_empty,
    output logic        o_hdr_pop,
    input  byte_beat_t  i_beat,
    input  logic        i_beat_empty,
    output logic        o_beat_pop,
    output logic [7:0]  o_tx_data,
    output logic        o_tx_valid,
    output logic        o_tx_last,
    input  logic        i_tx_ready
);

    typedef enum logic [1:0] {ST_IDLE, ST_HDR, ST_PAYLOAD} state_t;

    state_t                 state;
    logic [5:0]             byte_idx;
    logic [HDR_BYTES*8-1:0] hdr_vec;
    logic [HDR_BYTES*8-1:0] hdr_shift;   // Reply header, sent from the top byte
    logic [19:0]            sum_wide;
    logic [16:0]            sum_fold;
    logic [15:0]            csum;
    logic                   tx_fire;

    // Nonzero header words only; id, flags and checksum field are zero
    assign sum_wide = 20'({IP_VER_IHL, 8'h00}) +
                      20'(i_hdr.total_len) +
                      20'({REPLY_TTL, i_hdr.protocol}) +
                      20'(i_local.ip[31:16]) +
                      20'(i_local.ip[15:0]) +
                      20'(i_hdr.peer_ip[31:16]) +
                      20'(i_hdr.peer_ip[15:0]);
    assign sum_fold = {1'b0, sum_wide[15:0]} + {13'd0, sum_wide[19:16]};
    assign csum     = ~(sum_fold[15:0] + {15'd0, sum_fold[16]});

    assign hdr_vec = {
        i_hdr.peer_mac,         // Destination MAC
        i_local.mac,            // Source MAC
        ETH_TYPE_IPV4,
        IP_VER_IHL,
        8'h00,                  // TOS
        i_hdr.total_len,
        16'h0000,               // Identification
        16'h0000,               // Flags and fragment offset
        REPLY_TTL,
        i_hdr.protocol,
        csum,
        i_local.ip,             // Source IP
        i_hdr.peer_ip           // Destination IP
    };

    assign o_hdr_pop  = (state == ST_IDLE) && !i_hdr_empty;
    assign o_beat_pop = (state == ST_PAYLOAD) && !i_beat_empty && i_tx_ready;

    assign o_tx_valid = (state == ST_HDR) || ((state == ST_PAYLOAD) && !i_beat_empty);
    assign o_tx_data  = (state == ST_HDR) ? hdr_shift[HDR_BYTES*8-1 -: 8] : i_beat.data;
    assign o_tx_last  = (state == ST_PAYLOAD) && i_beat.last;
    assign tx_fire    = o_tx_valid && i_tx_ready;

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            state    <= ST_IDLE;
            byte_idx <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (o_hdr_pop) begin
                        state    <= ST_HDR;
                        byte_idx <= '0;
                    end
                end
                ST_HDR: begin
                    if (tx_fire) begin
                        if (byte_idx == 6'(HDR_BYTES - 1)) begin
                            state <= ST_PAYLOAD;
                        end else begin
                            byte_idx <= byte_idx + 6'd1;
                        end
                    end
                end
                default: begin
                    if (tx_fire && i_beat.last) begin
                        state <= ST_IDLE;   // Reply complete
                    end
                end
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (o_hdr_pop) begin
            hdr_shift <= hdr_vec;
        end else if ((state == ST_HDR) && tx_fire) begin
            hdr_shift <= {hdr_shift[HDR_BYTES*8-9:0], 8'h00};
        end
    end

    // Stream handshake hold rule on the transmit side
    a_tx_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (o_tx_valid && !i_tx_ready) |=>
            (o_tx_valid && $stable(o_tx_data) && $stable(o_tx_last)));

endmodule

// ==== source/ip_echo_top.sv ====
`timescale 1ns/10ps

module ip_echo_top
    import eth_ip_pkg::*;
(
    input  logic        i_clk,
    input  logic        i_rst_n,
    input  logic        i_cfg_wr,
    input  logic [1:0]  i_cfg_addr,
    input  logic [31:0] i_cfg_wdata,
    input  logic [7:0]  i_rx_data,
    input  logic        i_rx_valid,
    input  logic        i_rx_last,
    output logic        o_rx_ready,
    output logic [7:0]  o_tx_data,
    output logic        o_tx_valid,
    output logic        o_tx_last,
    input  logic        i_tx_ready,
    output logic [15:0] o_drop_count
);

    local_addr_t local_addr;
    rx_hdr_t     rx_hdr;
    rx_hdr_t     tx_hdr;
    byte_beat_t  rx_beat;
    byte_beat_t  tx_beat;
    logic        hdr_push;
    logic        hdr_full;
    logic        hdr_pop;
    logic        hdr_empty;
    logic        beat_push;
    logic        beat_full;
    logic        beat_pop;
    logic        beat_empty;
    logic        drop;

    ip_echo_regs u_regs (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_cfg_wr     (i_cfg_wr),
        .i_cfg_addr   (i_cfg_addr),
        .i_cfg_wdata  (i_cfg_wdata),
        .i_drop       (drop),
        .o_local      (local_addr),
        .o_drop_count (o_drop_count)
    );

    ip_rx_parser u_parser (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_local     (local_addr),
        .i_rx_data   (i_rx_data),
        .i_rx_valid  (i_rx_valid),
        .i_rx_last   (i_rx_last),
        .o_rx_ready  (o_rx_ready),
        .o_hdr       (rx_hdr),
        .o_hdr_push  (hdr_push),
        .i_hdr_full  (hdr_full),
        .o_beat      (rx_beat),
        .o_beat_push (beat_push),
        .i_beat_full (beat_full),
        .o_drop      (drop)
    );

    // One entry per accepted frame
    sync_fifo #(.T(rx_hdr_t), .DEPTH(HDR_FIFO_DEPTH)) u_hdr_fifo (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_push  (hdr_push),
        .i_data  (rx_hdr),
        .o_full  (hdr_full),
        .i_pop   (hdr_pop),
        .o_data  (tx_hdr),
        .o_empty (hdr_empty)
    );

    sync_fifo #(.T(byte_beat_t), .DEPTH(PAYLOAD_FIFO_DEPTH)) u_payload_fifo (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_push  (beat_push),
        .i_data  (rx_beat),
        .o_full  (beat_full),
        .i_pop   (beat_pop),
        .o_data  (tx_beat),
        .o_empty (beat_empty)
    );

    ip_tx_builder u_builder (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_local      (local_addr),
        .i_hdr        (tx_hdr),
        .i_hdr_empty  (hdr_empty),
        .o_hdr_pop    (hdr_pop),
        .i_beat       (tx_beat),
        .i_beat_empty (beat_empty),
        .o_beat_pop   (beat_pop),
        .o_tx_data    (o_tx_data),
        .o_tx_valid   (o_tx_valid),
        .o_tx_last    (o_tx_last),
        .i_tx_ready   (i_tx_ready)
    );

endmodule

// ==== verif/ip_echo_checker.sv ====
`timescale 1ns/10ps

module ip_echo_checker (
    input  logic        i_clk,
    input  logic        i_rst_n,
    input  logic        i_rx_ready,
    input  logic [7:0]  i_tx_data,
    input  logic        i_tx_valid,
    input  logic        i_tx_last,
    input  logic        i_tx_ready,
    input  logic [15:0] i_drop_count
);

    logic [8:0] exp_q [$];      // Expected beats as {last, data}
    logic [8:0] exp_beat;
    int         rd_idx = 0;
    int         stream_errors = 0;
    int         drop_errors = 0;

    task automatic expect_beat(input logic [7:0] data, input logic last);
        exp_q.push_back({last, data});
    endtask

    function automatic int pending_count();
        return exp_q.size() - rd_idx;
    endfunction

    function automatic int error_count();
        return stream_errors + drop_errors;
    endfunction

    task automatic check_drop_count(input logic [15:0] expected);
        if (i_drop_count !== expected) begin
            $display("ERROR %0t o_drop_count expected %0d actual %0d",
                     $time, expected, i_drop_count);
            drop_errors++;
        end
    endtask

    // Idle stream state right after reset
    task automatic check_reset_outputs();
        if (i_rx_ready !== 1'b1) begin
            $display("ERROR %0t o_rx_ready expected 1 actual %0b", $time, i_rx_ready);
            stream_errors++;
        end
        if (i_tx_valid !== 1'b0) begin
            $display("ERROR %0t o_tx_valid expected 0 actual %0b", $time, i_tx_valid);
            stream_errors++;
        end
    endtask

    // Outputs only move on rising edges, so the falling edge sees the beat
    // that the next rising edge transfers
    always @(negedge i_clk) begin
        if (i_rst_n && i_tx_valid && i_tx_ready) begin
            if (rd_idx >= exp_q.size()) begin
                $display("Reply byte 0x%02h sent at %0t while no reply was expected",
                         i_tx_data, $time);
                stream_errors++;
            end else begin
                exp_beat = exp_q[rd_idx];
                if (i_tx_data !== exp_beat[7:0]) begin
                    $display("ERROR %0t o_tx_data expected 0x%02h actual 0x%02h",
                             $time, exp_beat[7:0], i_tx_data);
                    stream_errors++;
                end
                if (i_tx_last !== exp_beat[8]) begin
                    $display("ERROR %0t o_tx_last expected %0b actual %0b",
                             $time, exp_beat[8], i_tx_last);
                    stream_errors++;
                end
                rd_idx++;
            end
        end
    end

endmodule

// ==== verif/tb_ip_echo.sv ====
`timescale 1ns/10ps

module tb_ip_echo
    import eth_ip_pkg::*;
();

    localparam int TOTAL_FRAMES   = 43;
    localparam int MAX_FRAME      = HDR_BYTES + 64;
    localparam int TIMEOUT_CYCLES = TOTAL_FRAMES * (MAX_FRAME * 4 + 50) + 2000;

    logic        clk       = 1'b0;
    logic        rst_n     = 1'b0;
    logic        cfg_wr    = 1'b0;
    logic [1:0]  cfg_addr  = '0;
    logic [31:0] cfg_wdata = '0;
    logic [7:0]  rx_data   = '0;
    logic        rx_valid  = 1'b0;
    logic        rx_last   = 1'b0;
    logic        rx_ready;
    logic [7:0]  tx_data;
    logic        tx_valid;
    logic        tx_last;
    logic        tx_ready  = 1'b1;
    logic [15:0] drop_count;

    integer      seed = 66;
    int          cycle_count = 0;
    logic [11:0] bp_idx = '0;
    logic        bp_on = 1'b0;
    logic        bp_pattern [4096];   // Precomputed i_tx_ready pattern
    logic [47:0] model_mac = DEFAULT_MAC;
    logic [31:0] model_ip  = DEFAULT_IP;
    logic [31:0] old_ip;
    int          exp_drops = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          errors_before = 0;

    ip_echo_top u_dut (
        .i_clk        (clk),
        .i_rst_n      (rst_n),
        .i_cfg_wr     (cfg_wr),
        .i_cfg_addr   (cfg_addr),
        .i_cfg_wdata  (cfg_wdata),
        .i_rx_data    (rx_data),
        .i_rx_valid   (rx_valid),
        .i_rx_last    (rx_last),
        .o_rx_ready   (rx_ready),
        .o_tx_data    (tx_data),
        .o_tx_valid   (tx_valid),
        .o_tx_last    (tx_last),
        .i_tx_ready   (tx_ready),
        .o_drop_count (drop_count)
    );

    ip_echo_checker u_chk (
        .i_clk        (clk),
        .i_rst_n      (rst_n),
        .i_rx_ready   (rx_ready),
        .i_tx_data    (tx_data),
        .i_tx_valid   (tx_valid),
        .i_tx_last    (tx_last),
        .i_tx_ready   (tx_ready),
        .i_drop_count (drop_count)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        bp_idx   <= bp_idx + 12'd1;
        tx_ready <= !bp_on || bp_pattern[bp_idx];
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the DUT stopped moving data", cycle_count);
            $display("*** FAILED ***");
            $finish;
        end
    end

    // Ones-complement sum of the ten header words, inverted
    function automatic logic [15:0] ip_checksum(input logic [159:0] hdr);
        logic [31:0]  sum;
        logic [159:0] words;
        sum   = '0;
        words = hdr;
        for (int i = 0; i < 10; i++) begin
            sum   = sum + 32'(words[159:144]);
            words = {words[143:0], 16'h0000};
        end
        sum = 32'(sum[15:0]) + 32'(sum[31:16]);
        sum = 32'(sum[15:0]) + 32'(sum[31:16]);
        return ~sum[15:0];
    endfunction

    task automatic send_byte(input logic [7:0] data, input logic last);
        rx_data  <= data;
        rx_valid <= 1'b1;
        rx_last  <= last;
        @(negedge clk);
        while (!rx_ready) begin
            @(negedge clk);
        end
        @(posedge clk);   // Byte taken on this edge
    endtask

    task automatic write_reg(input logic [1:0] addr, input logic [31:0] data);
        cfg_wr    <= 1'b1;
        cfg_addr  <= addr;
        cfg_wdata <= data;
        @(posedge clk);
        cfg_wr <= 1'b0;
    endtask

    task automatic send_frame(input logic [47:0] dst_mac, input logic [31:0] dst_ip,
                              input logic [15:0] eth_type, input logic bad_csum);
        logic [47:0]            src_mac;
        logic [31:0]            src_ip;
        logic [7:0]             proto;
        logic [15:0]            ident;
        logic [7:0]             ttl;
        logic [15:0]            total_len;
        logic [159:0]           ip_hdr;
        logic [159:0]           reply_hdr;
        logic [HDR_BYTES*8-1:0] rx_vec;
        logic [HDR_BYTES*8-1:0] tx_vec;
        logic [7:0]             payload [$];
        int                     len;
        logic                   keep;
        src_mac[47:32] = 16'($random(seed));
        src_mac[31:0]  = 32'($random(seed));
        src_ip         = 32'($random(seed));
        proto          = 8'($random(seed));
        ident          = 16'($random(seed));
        ttl            = 8'($random(seed));
        len            = 1 + int'({$random(seed)} % 32'd64);
        total_len      = 16'(20 + len);
        for (int i = 0; i < len; i++) begin
            payload.push_back(8'($random(seed)));
        end
        ip_hdr = {IP_VER_IHL, 8'h00, total_len, ident, 16'h0000, ttl, proto, 16'h0000,
                  src_ip, dst_ip};
        ip_hdr[79:64] = ip_checksum(ip_hdr);
        if (bad_csum) begin
            ip_hdr[79:64] = ip_hdr[79:64] ^ 16'h0101;
        end
        rx_vec = {dst_mac, src_mac, eth_type, ip_hdr};

        // Reply as the responder should build it
        keep = (eth_type == ETH_TYPE_IPV4) && !bad_csum && (dst_ip == model_ip) &&
               ((dst_mac == model_mac) || (dst_mac == BCAST_MAC));
        reply_hdr = {IP_VER_IHL, 8'h00, total_len, 16'h0000, 16'h0000, REPLY_TTL, proto,
                     16'h0000, model_ip, src_ip};
        reply_hdr[79:64] = ip_checksum(reply_hdr);
        tx_vec = {src_mac, model_mac, ETH_TYPE_IPV4, reply_hdr};
        if (keep) begin
            for (int i = 0; i < HDR_BYTES; i++) begin
                u_chk.expect_beat(tx_vec[HDR_BYTES*8-1 -: 8], 1'b0);
                tx_vec = {tx_vec[HDR_BYTES*8-9:0], 8'h00};
            end
            for (int i = 0; i < len; i++) begin
                u_chk.expect_beat(payload[i], i == len - 1);
            end
        end else begin
            exp_drops++;
        end

        for (int i = 0; i < HDR_BYTES; i++) begin
            send_byte(rx_vec[HDR_BYTES*8-1 -: 8], 1'b0);
            rx_vec = {rx_vec[HDR_BYTES*8-9:0], 8'h00};
        end
        for (int i = 0; i < len; i++) begin
            send_byte(payload[i], i == len - 1);
        end
    endtask

    task automatic finish_test(input string name);
        int errs;
        rx_valid <= 1'b0;
        rx_last  <= 1'b0;
        while (u_chk.pending_count() != 0) begin
            @(posedge clk);
        end
        repeat (4) @(negedge clk);   // Drop count lags the pulse by a cycle
        u_chk.check_drop_count(16'(exp_drops));
        errs          = u_chk.error_count() - errors_before;
        errors_before = u_chk.error_count();
        tests_run++;
        if (errs == 0) begin
            $display("Test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("Test %0d %s: %0d errors", tests_run, name, errs);
        end
        @(posedge clk);
    endtask

    initial begin
        for (int i = 0; i < 4096; i++) begin
            bp_pattern[12'(i)] = (({$random(seed)} % 32'd3) != 32'd0);
        end
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        u_chk.check_reset_outputs();
        u_chk.check_drop_count(16'd0);
        @(posedge clk);

        for (int i = 0; i < 8; i++) begin
            send_frame(model_mac, model_ip, ETH_TYPE_IPV4, 1'b0);
        end
        finish_test("valid frames echoed");

        for (int i = 0; i < 3; i++) begin
            send_frame(model_mac, model_ip ^ (32'd1 << i), ETH_TYPE_IPV4, 1'b0);
            send_frame(model_mac, model_ip, 16'h86DD, 1'b0);
            send_frame(model_mac ^ (48'd1 << (i + 8)), model_ip, ETH_TYPE_IPV4, 1'b0);
        end
        finish_test("wrong address or type dropped");

        for (int i = 0; i < 4; i++) begin
            send_frame(model_mac, model_ip, ETH_TYPE_IPV4, 1'b1);
        end
        finish_test("bad checksum dropped");

        for (int i = 0; i < 4; i++) begin
            send_frame(BCAST_MAC, model_ip, ETH_TYPE_IPV4, 1'b0);
        end
        finish_test("broadcast echoed");

        old_ip    = model_ip;
        model_ip  = 32'h0A_00_00_05;
        model_mac = 48'h02_AB_CD_EF_01_23;
        write_reg(CFG_ADDR_IP, model_ip);
        write_reg(CFG_ADDR_MAC_LO, model_mac[31:0]);
        write_reg(CFG_ADDR_MAC_HI, {16'h0000, model_mac[47:32]});
        for (int i = 0; i < 4; i++) begin
            send_frame(model_mac, model_ip, ETH_TYPE_IPV4, 1'b0);
        end
        send_frame(model_mac, old_ip, ETH_TYPE_IPV4, 1'b0);
        send_frame(model_mac, old_ip, ETH_TYPE_IPV4, 1'b0);
        finish_test("new local address");

        bp_on <= 1'b1;
        for (int i = 0; i < 12; i++) begin
            send_frame(model_mac, model_ip, ETH_TYPE_IPV4, 1'b0);
        end
        finish_test("back-pressure");
        bp_on <= 1'b0;

        $display("Tests run %0d, failed %0d, errors %0d",
                 tests_run, tests_failed, u_chk.error_count());
        if ((tests_failed == 0) && (u_chk.error_count() == 0)) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== ip_echo_top.f ====
common/eth_ip_pkg.sv
source/ip_echo_regs.sv
ip_rx/ip_rx_parser.sv
source/sync_fifo.sv
ip_tx/ip_tx_builder.sv
source/ip_echo_top.sv
verif/ip_echo_checker.sv
verif/tb_ip_echo.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_ip_echo -f ip_echo_top.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/Vtb_ip_echo)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qF '*** PASSED ***'; then
    exit 0
fi
exit 1
